// ==== sources.f ====
+incdir+rtl
rtl/memRrPkg.sv
rtl/physRegFile.sv
rtl/selectiveFlush.sv
rtl/memRegReadStage.sv
rtl/memRrTop.sv
verif/memRrTb.sv

// ==== verif/memRrTb.sv ====
`timescale 1ns/1ps
// --------------------
// Memory register-read testbench
// Seeded random ops, write-back and recovery against a shadow model
// --------------------
`include "memRr_params.svh"

module memRrTb import memRrPkg::*; ();

    localparam int RegNum = `MEMRR_PREG_NUM;
    localparam int RandomCycles = 3000;
    localparam int ReadyTimeout = 16;

    logic clk;
    logic arstN;
    logic inValid;
    memOpType_t inOpType;
    operandType_t inOperandTypeA;
    operandType_t inOperandTypeB;
    pRegNum_t inSrcA;
    pRegNum_t inSrcB;
    addr_t inPc;
    pRegNum_t inDstReg;
    logic inWriteReg;
    alPtr_t inAlPtr;
    logic inHasMshr;
    mshrId_t inMshrId;
    logic stall;
    logic clear;
    logic recoveryActive;
    logic flushAll;
    alPtr_t flushHead;
    alPtr_t flushTail;
    logic wbEn;
    pRegNum_t wbReg;
    data_t wbData;

    logic outValid;
    memOpType_t outOpType;
    data_t outOperandA;
    data_t outOperandB;
    logic outOperandAValid;
    logic outOperandBValid;
    pRegNum_t outDstReg;
    logic outWriteReg;
    alPtr_t outAlPtr;
    mshrVec_t mshrRelease;

    // Shadow register file
    data_t mRegData [RegNum];
    logic [RegNum-1:0] mRegReady;

    // Shadow pipeline register
    logic pValid;
    memOpType_t pOpType;
    operandType_t pTypeA;
    operandType_t pTypeB;
    pRegNum_t pSrcA;
    pRegNum_t pSrcB;
    addr_t pPc;
    pRegNum_t pDst;
    logic pWriteReg;
    alPtr_t pAlPtr;
    logic pHasMshr;
    mshrId_t pMshrId;

    integer seed;
    int waitCount;
    int cyc;

    memRrTop i_dut (.*);

    always #4 clk = ~clk;

    task automatic abortRun();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkData(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkRegNum(input string name, input pRegNum_t got, input pRegNum_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkMshr(input string name, input mshrVec_t got, input mshrVec_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkOpType(input string name, input memOpType_t got, input memOpType_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkAlPtr(input string name, input alPtr_t got, input alPtr_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    // Distance from head, modulo the list size, decides membership
    function automatic logic expectInRange(input alPtr_t ptr);
        alPtr_t offset;
        alPtr_t span;
        offset = ptr - flushHead;
        span = flushTail - flushHead;
        if (!recoveryActive) begin
            return 1'b0;
        end else if (flushAll) begin
            return 1'b1;
        end
        return offset < span;
    endfunction

    task automatic checkOperand(input string dataName, input string validName,
                                input operandType_t opType, input pRegNum_t src,
                                input data_t gotData, input logic gotValid);
        data_t expData;
        logic expValid;
        expValid = 1'b1;
        if (opType == OOT_IMM) begin
            expData = '0;
        end else if (opType == OOT_PC) begin
            expData = pPc;
        end else begin
            expData = mRegData[src];
            expValid = mRegReady[src];
        end
        checkValid(validName, gotValid, expValid);
        // Data of a register never written is unknown
        if (expValid) begin
            checkData(dataName, gotData, expData);
        end
    endtask

    task automatic checkOutputs();
        logic flushed;
        mshrVec_t expMshr;
        flushed = expectInRange(pAlPtr);
        expMshr = '0;
        if (pValid && pOpType == MOP_LOAD && pHasMshr && flushed) begin
            expMshr[pMshrId] = 1'b1;
        end
        checkValid("outValid", outValid, pValid && !stall && !clear && !flushed);
        checkValid("outWriteReg", outWriteReg, pWriteReg && pValid);
        checkOpType("outOpType", outOpType, pOpType);
        checkRegNum("outDstReg", outDstReg, pDst);
        checkAlPtr("outAlPtr", outAlPtr, pAlPtr);
        checkOperand("outOperandA", "outOperandAValid", pTypeA, pSrcA,
                     outOperandA, outOperandAValid);
        checkOperand("outOperandB", "outOperandBValid", pTypeB, pSrcB,
                     outOperandB, outOperandBValid);
        checkMshr("mshrRelease", mshrRelease, expMshr);
    endtask

    // Mirror of what the DUT captures at a rising edge
    task automatic stepModel();
        if (wbEn) begin
            mRegData[wbReg] = wbData;
            if (arstN) begin
                mRegReady[wbReg] = 1'b1;
            end
        end
        if (!arstN) begin
            mRegReady = '0;
        end
        if (!stall) begin
            pValid = inValid && arstN;
            pOpType = inOpType;
            pTypeA = inOperandTypeA;
            pTypeB = inOperandTypeB;
            pSrcA = inSrcA;
            pSrcB = inSrcB;
            pPc = inPc;
            pDst = inDstReg;
            pWriteReg = inWriteReg;
            pAlPtr = inAlPtr;
            pHasMshr = inHasMshr;
            pMshrId = inMshrId;
        end else if (!arstN) begin
            pValid = 1'b0;
        end
    endtask

    task automatic randomizeInputs();
        inValid = ($unsigned($random(seed)) % 4) != 0;
        inOpType = memOpType_t'($unsigned($random(seed)) % 3);
        inOperandTypeA = operandType_t'($unsigned($random(seed)) % 3);
        inOperandTypeB = operandType_t'($unsigned($random(seed)) % 3);
        inSrcA = $random(seed);
        inSrcB = $random(seed);
        inPc = $random(seed);
        inDstReg = $random(seed);
        inWriteReg = $random(seed);
        inAlPtr = $random(seed);
        inHasMshr = $random(seed);
        inMshrId = $random(seed);
        stall = ($unsigned($random(seed)) % 8) == 0;
        clear = ($unsigned($random(seed)) % 8) == 0;
        recoveryActive = ($unsigned($random(seed)) % 4) == 0;
        flushAll = ($unsigned($random(seed)) % 8) == 0;
        flushHead = $random(seed);
        flushTail = $random(seed);
        // Empty range now and then
        if (($unsigned($random(seed)) % 8) == 0) begin
            flushTail = flushHead;
        end
        wbEn = $random(seed);
        wbData = $random(seed);
        wbReg = $random(seed);
        // Hit the latched source to cover a write in the same cycle as the read
        if (($unsigned($random(seed)) % 4) == 0) begin
            wbReg = pSrcA;
        end
    endtask

    task automatic runCycle(input logic freshInputs);
        @(posedge clk);
        stepModel();
        #1;
        if (freshInputs) begin
            randomizeInputs();
        end
        #6;
        checkOutputs();
    endtask

    initial begin
        seed = 32'h6057;
        clk = 1'b0;
        arstN = 1'b0;
        inValid = 1'b0;
        inOpType = MOP_LOAD;
        inOperandTypeA = OOT_REG;
        inOperandTypeB = OOT_REG;
        inSrcA = '0;
        inSrcB = '0;
        inPc = '0;
        inDstReg = '0;
        inWriteReg = 1'b0;
        inAlPtr = '0;
        inHasMshr = 1'b0;
        inMshrId = '0;
        stall = 1'b0;
        clear = 1'b0;
        recoveryActive = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        wbEn = 1'b0;
        wbReg = '0;
        wbData = '0;
        mRegReady = '0;
        pValid = 1'b0;

        // Reset phase keeps outValid low throughout
        for (cyc = 0; cyc < 9; cyc++) begin
            runCycle(1'b0);
        end

        // Last reset edge, then release and write register 5 while reading it
        @(posedge clk);
        stepModel();
        #1;
        arstN = 1'b1;
        inValid = 1'b1;
        inSrcA = 6'd5;
        wbEn = 1'b1;
        wbReg = 6'd5;
        wbData = 32'h1234_abcd;
        #6;
        checkOutputs();

        // Wait until a read of register 5 reports ready
        waitCount = 0;
        runCycle(1'b0);
        while (!outOperandAValid && waitCount < ReadyTimeout) begin
            runCycle(1'b0);
            waitCount++;
        end
        if (!outOperandAValid) begin
            $display("register 5 never reported ready after its write-back");
            abortRun();
        end

        for (cyc = 0; cyc < RandomCycles; cyc++) begin
            runCycle(1'b1);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== rtl/memRrTop.sv ====
`timescale 1ns/1ps
// --------------------
// Memory register-read top
// Stage, register file and flush detector side by side
// --------------------

module memRrTop import memRrPkg::*; (
    input  logic         clk,
    input  logic         arstN,

    // Issued op
    input  logic         inValid,
    input  memOpType_t   inOpType,
    input  operandType_t inOperandTypeA,
    input  operandType_t inOperandTypeB,
    input  pRegNum_t     inSrcA,
    input  pRegNum_t     inSrcB,
    input  addr_t        inPc,
    input  pRegNum_t     inDstReg,
    input  logic         inWriteReg,
    input  alPtr_t       inAlPtr,
    input  logic         inHasMshr,
    input  mshrId_t      inMshrId,

    // Pipeline control
    input  logic         stall,
    input  logic         clear,

    // Recovery
    input  logic         recoveryActive,
    input  logic         flushAll,
    input  alPtr_t       flushHead,
    input  alPtr_t       flushTail,

    // Write-back
    input  logic         wbEn,
    input  pRegNum_t     wbReg,
    input  data_t        wbData,

    // Results
    output logic         outValid,
    output memOpType_t   outOpType,
    output data_t        outOperandA,
    output data_t        outOperandB,
    output logic         outOperandAValid,
    output logic         outOperandBValid,
    output pRegNum_t     outDstReg,
    output logic         outWriteReg,
    output alPtr_t       outAlPtr,
    output mshrVec_t     mshrRelease
);

    pRegNum_t rdRegA;
    pRegNum_t rdRegB;
    data_t    rdDataA;
    data_t    rdDataB;
    logic     rdReadyA;
    logic     rdReadyB;
    alPtr_t   alPtr;
    logic     inRange;

    memRegReadStage i_stage (
        .clk              (clk),
        .arstN            (arstN),
        .inValid          (inValid),
        .inOpType         (inOpType),
        .inOperandTypeA   (inOperandTypeA),
        .inOperandTypeB   (inOperandTypeB),
        .inSrcA           (inSrcA),
        .inSrcB           (inSrcB),
        .inPc             (inPc),
        .inDstReg         (inDstReg),
        .inWriteReg       (inWriteReg),
        .inAlPtr          (inAlPtr),
        .inHasMshr        (inHasMshr),
        .inMshrId         (inMshrId),
        .stall            (stall),
        .clear            (clear),
        .rdRegA           (rdRegA),
        .rdRegB           (rdRegB),
        .rdDataA          (rdDataA),
        .rdDataB          (rdDataB),
        .rdReadyA         (rdReadyA),
        .rdReadyB         (rdReadyB),
        .alPtr            (alPtr),
        .inRange          (inRange),
        .outValid         (outValid),
        .outOpType        (outOpType),
        .outOperandA      (outOperandA),
        .outOperandB      (outOperandB),
        .outOperandAValid (outOperandAValid),
        .outOperandBValid (outOperandBValid),
        .outDstReg        (outDstReg),
        .outWriteReg      (outWriteReg),
        .outAlPtr         (outAlPtr),
        .mshrRelease      (mshrRelease)
    );

    physRegFile i_regFile (
        .clk      (clk),
        .arstN    (arstN),
        .rdRegA   (rdRegA),
        .rdDataA  (rdDataA),
        .rdReadyA (rdReadyA),
        .rdRegB   (rdRegB),
        .rdDataB  (rdDataB),
        .rdReadyB (rdReadyB),
        .wbEn     (wbEn),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    selectiveFlush i_flush (
        .recoveryActive (recoveryActive),
        .flushAll       (flushAll),
        .flushHead      (flushHead),
        .flushTail      (flushTail),
        .alPtr          (alPtr),
        .inRange        (inRange)
    );

endmodule

// ==== rtl/memRegReadStage.sv ====
`timescale 1ns/1ps
// --------------------
// Memory register-read stage
// Latches one issued memory op, picks its operands and kills it on stall,
// clear or flush; releases the MSHR of a flushed load
// --------------------

module memRegReadStage import memRrPkg::*; (
    input  logic         clk,
    input  logic         arstN,

    // Issued op
    input  logic         inValid,
    input  memOpType_t   inOpType,
    input  operandType_t inOperandTypeA,
    input  operandType_t inOperandTypeB,
    input  pRegNum_t     inSrcA,
    input  pRegNum_t     inSrcB,
    input  addr_t        inPc,
    input  pRegNum_t     inDstReg,
    input  logic         inWriteReg,
    input  alPtr_t       inAlPtr,
    input  logic         inHasMshr,
    input  mshrId_t      inMshrId,

    // Pipeline control
    input  logic         stall,
    input  logic         clear,

    // Register file
    output pRegNum_t     rdRegA,
    output pRegNum_t     rdRegB,
    input  data_t        rdDataA,
    input  data_t        rdDataB,
    input  logic         rdReadyA,
    input  logic         rdReadyB,

    // Flush detector
    output alPtr_t       alPtr,
    input  logic         inRange,

    // To the execution stage
    output logic         outValid,
    output memOpType_t   outOpType,
    output data_t        outOperandA,
    output data_t        outOperandB,
    output logic         outOperandAValid,
    output logic         outOperandBValid,
    output pRegNum_t     outDstReg,
    output logic         outWriteReg,
    output alPtr_t       outAlPtr,
    output mshrVec_t     mshrRelease
);

    // Memory ops carry no immediate here
    localparam data_t ImmZero = '0;

    // Pipeline register
    logic         pipeValid;
    memOpType_t   pipeOpType;
    operandType_t pipeOperandTypeA;
    operandType_t pipeOperandTypeB;
    pRegNum_t     pipeSrcA;
    pRegNum_t     pipeSrcB;
    addr_t        pipePc;
    pRegNum_t     pipeDstReg;
    logic         pipeWriteReg;
    alPtr_t       pipeAlPtr;
    logic         pipeHasMshr;
    mshrId_t      pipeMshrId;

    logic isLoad;
    logic releaseMshr;

    function automatic data_t selectOperand(
        input operandType_t opType,
        input data_t        regValue,
        input data_t        immValue,
        input data_t        pcValue
    );
        data_t result;
        case (opType)
            OOT_IMM: result = immValue;
            OOT_PC:  result = pcValue;
            default: result = regValue;
        endcase
        return result;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= inValid;
        end
    end

    // Payload fields hold while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeOpType       <= inOpType;
            pipeOperandTypeA <= inOperandTypeA;
            pipeOperandTypeB <= inOperandTypeB;
            pipeSrcA         <= inSrcA;
            pipeSrcB         <= inSrcB;
            pipePc           <= inPc;
            pipeDstReg       <= inDstReg;
            pipeWriteReg     <= inWriteReg;
            pipeAlPtr        <= inAlPtr;
            pipeHasMshr      <= inHasMshr;
            pipeMshrId       <= inMshrId;
        end
    end

    // Register file and flush lookups
    assign rdRegA = pipeSrcA;
    assign rdRegB = pipeSrcB;
    assign alPtr  = pipeAlPtr;

    // Operand selection
    assign outOperandA = selectOperand(pipeOperandTypeA, rdDataA, ImmZero, data_t'(pipePc));
    assign outOperandB = selectOperand(pipeOperandTypeB, rdDataB, ImmZero, data_t'(pipePc));

    // Only a register source can be waiting on a producer
    assign outOperandAValid = (pipeOperandTypeA != OOT_REG) || rdReadyA;
    assign outOperandBValid = (pipeOperandTypeB != OOT_REG) || rdReadyB;

    // Kill on stall, clear or squash
    assign outValid = pipeValid && !stall && !clear && !inRange;

    assign outOpType   = pipeOpType;
    assign outDstReg   = pipeDstReg;
    assign outWriteReg = pipeWriteReg && pipeValid;
    assign outAlPtr    = pipeAlPtr;

    // A squashed load gives back the MSHR it allocated
    assign isLoad      = (pipeOpType == MOP_LOAD);
    assign releaseMshr = pipeValid && isLoad && pipeHasMshr && inRange;
    assign mshrRelease = releaseMshr ? (mshrVec_t'(1) << pipeMshrId) : '0;

endmodule

// ==== rtl/selectiveFlush.sv ====
`timescale 1ns/1ps
// --------------------
// Selective flush detector
// Flags an active-list pointer inside the circular squash range
// --------------------

module selectiveFlush import memRrPkg::*; (
    input  logic   recoveryActive,
    input  logic   flushAll,
    input  alPtr_t flushHead,
    input  alPtr_t flushTail,
    input  alPtr_t alPtr,
    output logic   inRange
);

    logic aboveHead;
    logic belowTail;
    logic wrapped;
    logic emptyRange;

    // Half-open range [flushHead, flushTail)
    assign aboveHead  = (alPtr >= flushHead);
    assign belowTail  = (alPtr < flushTail);
    assign emptyRange = (flushHead == flushTail);

    // Tail has wrapped past the end of the list
    assign wrapped = (flushTail < flushHead);

    always_comb begin
        if (!recoveryActive) begin
            inRange = 1'b0;
        end else if (flushAll) begin
            inRange = 1'b1;
        end else if (emptyRange) begin
            inRange = 1'b0;
        end else if (wrapped) begin
            // Union of [head, end] and [0, tail)
            inRange = aboveHead || belowTail;
        end else begin
            inRange = aboveHead && belowTail;
        end
    end

endmodule

// ==== rtl/physRegFile.sv ====
`timescale 1ns/1ps
// --------------------
// Physical register file
// Two combinational read ports, one write port, ready bit per register
// --------------------
`include "memRr_params.svh"

module physRegFile import memRrPkg::*; (
    input  logic     clk,
    input  logic     arstN,

    // Read port A
    input  pRegNum_t rdRegA,
    output data_t    rdDataA,
    output logic     rdReadyA,

    // Read port B
    input  pRegNum_t rdRegB,
    output data_t    rdDataB,
    output logic     rdReadyB,

    // Write-back port
    input  logic     wbEn,
    input  pRegNum_t wbReg,
    input  data_t    wbData
);

    localparam int RegNum = `MEMRR_PREG_NUM;

    // Register storage
    data_t regData [RegNum];

    // Set once a register has been written since reset
    logic [RegNum-1:0] regReady;

    always_ff @(posedge clk) begin
        if (wbEn) begin
            regData[wbReg] <= wbData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regReady <= '0;
        end else if (wbEn) begin
            regReady[wbReg] <= 1'b1;
        end
    end

    // Reads see the stored state only, so a same-cycle write shows up next cycle
    assign rdDataA  = regData[rdRegA];
    assign rdReadyA = regReady[rdRegA];

    assign rdDataB  = regData[rdRegB];
    assign rdReadyB = regReady[rdRegB];

endmodule

// ==== rtl/memRrPkg.sv ====
// --------------------
// Memory register-read types
// Vector typedefs and FSM-free enums shared by the memory pipe
// --------------------
`include "memRr_params.svh"

package memRrPkg;

    // Physical register number
    typedef logic [$clog2(`MEMRR_PREG_NUM)-1:0] pRegNum_t;

    // Operand data and PC
    typedef logic [`MEMRR_DATA_WIDTH-1:0] data_t;
    typedef logic [`MEMRR_DATA_WIDTH-1:0] addr_t;

    // Position in the active list
    typedef logic [$clog2(`MEMRR_AL_NUM)-1:0] alPtr_t;

    // MSHR index and one-hot release vector
    typedef logic [$clog2(`MEMRR_MSHR_NUM)-1:0] mshrId_t;
    typedef logic [`MEMRR_MSHR_NUM-1:0] mshrVec_t;

    // Source of each operand
    typedef enum logic [1:0] {
        OOT_REG = 2'd0,
        OOT_IMM = 2'd1,
        OOT_PC  = 2'd2
    } operandType_t;

    // Kind of memory op
    typedef enum logic [1:0] {
        MOP_LOAD  = 2'd0,
        MOP_STORE = 2'd1,
        MOP_FENCE = 2'd2
    } memOpType_t;

endpackage

// ==== rtl/memRr_params.svh ====
// --------------------
// Memory register-read sizing
// Register file, active list and MSHR counts
// --------------------
`ifndef MEMRR_PARAMS_SVH
`define MEMRR_PARAMS_SVH

// Physical registers, one data word each
`define MEMRR_PREG_NUM 64

// Data path width in bits
`define MEMRR_DATA_WIDTH 32

// Active-list entries
`define MEMRR_AL_NUM 32

// Miss-handling entries
`define MEMRR_MSHR_NUM 4

`endif
